/* design/csr_pkg.sv */
package csr_pkg;

    // Architectural CSR numbers
    typedef enum logic [13:0] {
        CSR_CRMD   = 14'h000,
        CSR_PRMD   = 14'h001,
        CSR_ECFG   = 14'h004,
        CSR_ESTAT  = 14'h005,
        CSR_ERA    = 14'h006,
        CSR_BADV   = 14'h007,
        CSR_EENTRY = 14'h00c,
        CSR_SAVE0  = 14'h030,
        CSR_TID    = 14'h040,
        CSR_TCFG   = 14'h041,
        CSR_TVAL   = 14'h042,
        CSR_TICLR  = 14'h044
    } csr_num_e;

    // One selector per kept register
    typedef enum logic [3:0] {
        SEL_CRMD,
        SEL_PRMD,
        SEL_ECFG,
        SEL_ESTAT,
        SEL_ERA,
        SEL_BADV,
        SEL_EENTRY,
        SEL_SAVE,
        SEL_TID,
        SEL_TCFG,
        SEL_TVAL,
        SEL_TICLR,
        SEL_NONE
    } csr_sel_e;

    typedef enum logic [5:0] {
        ECODE_INT = 6'h00,
        ECODE_ADE = 6'h08,
        ECODE_ALE = 6'h09,
        ECODE_SYS = 6'h0b,
        ECODE_BRK = 6'h0c,
        ECODE_INE = 6'h0d
    } ecode_e;

    // Fetch address error
    localparam logic [8:0] ESUBCODE_ADEF = 9'd0;

    localparam int CRMD_PLV_LSB  = 0;
    localparam int CRMD_IE       = 2;
    localparam int CRMD_DA       = 3;
    localparam int CRMD_PG       = 4;
    localparam int CRMD_DATF_LSB = 5;
    localparam int CRMD_DATM_LSB = 7;

    localparam int PRMD_PPLV_LSB = 0;
    localparam int PRMD_PIE      = 2;

    localparam int ESTAT_IS_LSB       = 0;
    localparam int ESTAT_IS_W         = 13;
    localparam int ESTAT_ECODE_LSB    = 16;
    localparam int ESTAT_ESUBCODE_LSB = 22;

    localparam int EENTRY_VA_LSB = 6;

    localparam int TCFG_EN          = 0;
    localparam int TCFG_PERIODIC    = 1;
    localparam int TCFG_INITVAL_LSB = 2;

    localparam int TICLR_CLR     = 0;
    localparam int TIMER_INT_BIT = 11;

    // Bit 10 of LIE is reserved
    localparam logic [12:0] ECFG_LIE_MASK = 13'h1bff;

    typedef struct packed {
        logic [13:0] num;
        logic        re;
        logic        we;
        logic [31:0] wvalue;
        logic [31:0] wmask;
    } csr_req_t;

    typedef struct packed {
        logic        ex;
        logic        ertn;
        ecode_e      ecode;
        logic [8:0]  esubcode;
        logic [31:0] pc;
        logic [31:0] vaddr;
    } trap_event_t;

    typedef struct packed {
        csr_sel_e    sel;
        logic [3:0]  save_idx;
        logic        wr;
        logic [31:0] wvalue;
        logic [31:0] wmask;
    } csr_write_t;

    typedef struct packed {
        logic [31:0] tid;
        logic [31:0] tcfg;
        logic [31:0] tval;
    } timer_view_t;

    // Raw trap state fields, SAVE words travel alongside
    typedef struct packed {
        logic [1:0]  crmd_plv;
        logic        crmd_ie;
        logic        crmd_da;
        logic        crmd_pg;
        logic [1:0]  crmd_datf;
        logic [1:0]  crmd_datm;
        logic [1:0]  prmd_pplv;
        logic        prmd_pie;
        logic [12:0] ecfg_lie;
        logic [12:0] estat_is;
        ecode_e      estat_ecode;
        logic [8:0]  estat_esubcode;
        logic [31:0] era;
        logic [25:0] eentry_va;
        logic [31:0] badv;
    } trap_regs_t;

endpackage

/* design/csr_decode.sv */
module csr_decode #(
    parameter int SAVE_COUNT = 4
) (
    input  csr_pkg::csr_req_t   req,
    input  logic                valid,
    output csr_pkg::csr_write_t write,
    output csr_pkg::csr_sel_e   rd_sel,
    output logic [3:0]          rd_save_idx
);
    import csr_pkg::*;

    csr_sel_e    sel;
    logic [13:0] save_off;
    logic [3:0]  save_idx;

    // Below SAVE0 the offset wraps high and fails the range check
    assign save_off = req.num - CSR_SAVE0;

    always_comb begin
        sel      = SEL_NONE;
        save_idx = '0;
        case (req.num)
            CSR_CRMD:   sel = SEL_CRMD;
            CSR_PRMD:   sel = SEL_PRMD;
            CSR_ECFG:   sel = SEL_ECFG;
            CSR_ESTAT:  sel = SEL_ESTAT;
            CSR_ERA:    sel = SEL_ERA;
            CSR_BADV:   sel = SEL_BADV;
            CSR_EENTRY: sel = SEL_EENTRY;
            CSR_TID:    sel = SEL_TID;
            CSR_TCFG:   sel = SEL_TCFG;
            CSR_TVAL:   sel = SEL_TVAL;
            CSR_TICLR:  sel = SEL_TICLR;
            default: begin
                if (save_off < 14'(SAVE_COUNT)) begin
                    sel      = SEL_SAVE;
                    save_idx = save_off[3:0];
                end
            end
        endcase
    end

    // Write strobe needs valid and a known register
    assign write.sel      = sel;
    assign write.save_idx = save_idx;
    assign write.wr       = req.we && valid && (sel != SEL_NONE);
    assign write.wvalue   = req.wvalue;
    assign write.wmask    = req.wmask;

    assign rd_sel      = sel;
    assign rd_save_idx = save_idx;

endmodule

/* design/csr_trap_state.sv */
module csr_trap_state #(
    parameter int SAVE_COUNT = 4
) (
    input  logic                 clk,
    input  logic                 reset,
    input  csr_pkg::csr_write_t  write,
    input  csr_pkg::trap_event_t trap,
    input  logic                 timer_int,
    output logic [$bits(csr_pkg::trap_regs_t)+32*SAVE_COUNT-1:0] trap_view,
    output logic [31:0]          ex_entry,
    output logic [31:0]          era_pc,
    output logic                 has_int
);
    import csr_pkg::*;

    logic [1:0]  crmd_plv;
    logic        crmd_ie;
    logic        crmd_da;
    logic        crmd_pg;
    logic [1:0]  crmd_datf;
    logic [1:0]  crmd_datm;
    logic [1:0]  prmd_pplv;
    logic        prmd_pie;
    logic [12:0] ecfg_lie;
    logic [1:0]  estat_is_sw;
    logic [ESTAT_IS_W-1:0] estat_is;
    ecode_e      estat_ecode;
    logic [8:0]  estat_esubcode;
    logic [31:0] era;
    logic [25:0] eentry_va;
    logic [31:0] badv;
    logic [SAVE_COUNT-1:0][31:0] save;

    trap_regs_t  regs;
    logic [31:0] wset;
    logic [31:0] wkeep;
    logic        sw_wr;
    logic        addr_err;

    assign wset  = write.wvalue & write.wmask;
    assign wkeep = ~write.wmask;

    // Exception and return both take priority over software
    assign sw_wr = write.wr && !trap.ex && !trap.ertn;

    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_plv  <= 2'b00;
            crmd_ie   <= 1'b0;
            crmd_da   <= 1'b1;
            crmd_pg   <= 1'b0;
            crmd_datf <= 2'b00;
            crmd_datm <= 2'b00;
        end else if (trap.ex) begin
            crmd_plv <= 2'b00;
            crmd_ie  <= 1'b0;
        end else if (trap.ertn) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (sw_wr && write.sel == SEL_CRMD) begin
            crmd_plv  <= wset[CRMD_PLV_LSB +: 2] | (crmd_plv & wkeep[CRMD_PLV_LSB +: 2]);
            crmd_ie   <= wset[CRMD_IE] | (crmd_ie & wkeep[CRMD_IE]);
            crmd_da   <= wset[CRMD_DA] | (crmd_da & wkeep[CRMD_DA]);
            crmd_pg   <= wset[CRMD_PG] | (crmd_pg & wkeep[CRMD_PG]);
            crmd_datf <= wset[CRMD_DATF_LSB +: 2] | (crmd_datf & wkeep[CRMD_DATF_LSB +: 2]);
            crmd_datm <= wset[CRMD_DATM_LSB +: 2] | (crmd_datm & wkeep[CRMD_DATM_LSB +: 2]);
        end
    end

    // Previous mode saved on entry
    always_ff @(posedge clk) begin
        if (trap.ex) begin
            prmd_pplv <= crmd_plv;
            prmd_pie  <= crmd_ie;
        end else if (sw_wr && write.sel == SEL_PRMD) begin
            prmd_pplv <= wset[PRMD_PPLV_LSB +: 2] | (prmd_pplv & wkeep[PRMD_PPLV_LSB +: 2]);
            prmd_pie  <= wset[PRMD_PIE] | (prmd_pie & wkeep[PRMD_PIE]);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ecfg_lie <= '0;
        end else if (sw_wr && write.sel == SEL_ECFG) begin
            ecfg_lie <= (wset[12:0] | (ecfg_lie & wkeep[12:0])) & ECFG_LIE_MASK;
        end
    end

    // Only the two software interrupt bits are writable
    always_ff @(posedge clk) begin
        if (reset) begin
            estat_is_sw <= 2'b00;
        end else if (sw_wr && write.sel == SEL_ESTAT) begin
            estat_is_sw <= wset[ESTAT_IS_LSB +: 2] | (estat_is_sw & wkeep[ESTAT_IS_LSB +: 2]);
        end
    end

    always_comb begin
        estat_is                = '0;
        estat_is[1:0]           = estat_is_sw;
        estat_is[TIMER_INT_BIT] = timer_int;
    end

    always_ff @(posedge clk) begin
        if (trap.ex) begin
            estat_ecode    <= trap.ecode;
            estat_esubcode <= trap.esubcode;
        end
    end

    always_ff @(posedge clk) begin
        if (trap.ex) begin
            era <= trap.pc;
        end else if (sw_wr && write.sel == SEL_ERA) begin
            era <= wset | (era & wkeep);
        end
    end

    always_ff @(posedge clk) begin
        if (sw_wr && write.sel == SEL_EENTRY) begin
            eentry_va <= wset[31:EENTRY_VA_LSB] | (eentry_va & wkeep[31:EENTRY_VA_LSB]);
        end
    end

    assign addr_err = (trap.ecode == ECODE_ADE) || (trap.ecode == ECODE_ALE);

    // Fetch errors record the pc, data errors the address
    always_ff @(posedge clk) begin
        if (trap.ex && addr_err) begin
            if (trap.ecode == ECODE_ADE && trap.esubcode == ESUBCODE_ADEF) begin
                badv <= trap.pc;
            end else begin
                badv <= trap.vaddr;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < SAVE_COUNT; i++) begin
            if (sw_wr && write.sel == SEL_SAVE && write.save_idx == 4'(i)) begin
                save[i] <= wset | (save[i] & wkeep);
            end
        end
    end

    assign regs = '{
        crmd_plv:       crmd_plv,
        crmd_ie:        crmd_ie,
        crmd_da:        crmd_da,
        crmd_pg:        crmd_pg,
        crmd_datf:      crmd_datf,
        crmd_datm:      crmd_datm,
        prmd_pplv:      prmd_pplv,
        prmd_pie:       prmd_pie,
        ecfg_lie:       ecfg_lie,
        estat_is:       estat_is,
        estat_ecode:    estat_ecode,
        estat_esubcode: estat_esubcode,
        era:            era,
        eentry_va:      eentry_va,
        badv:           badv
    };

    assign trap_view = {save, regs};

    assign ex_entry = {eentry_va, 6'b0};
    assign era_pc   = era;
    assign has_int  = crmd_ie && ((estat_is & ecfg_lie) != '0);

endmodule

/* design/csr_timer.sv */
module csr_timer (
    input  logic                clk,
    input  logic                reset,
    input  csr_pkg::csr_write_t write,
    output logic                timer_int,
    output csr_pkg::timer_view_t timer_view
);
    import csr_pkg::*;

    logic [31:0] tid;
    logic        tcfg_en;
    logic        tcfg_periodic;
    logic [29:0] tcfg_initval;
    logic [31:0] tcfg_cur;
    logic [31:0] tcfg_next;
    logic [31:0] count;
    logic [31:0] wset;
    logic [31:0] wkeep;
    logic        wr_tcfg;
    logic        count_zero;

    assign wset  = write.wvalue & write.wmask;
    assign wkeep = ~write.wmask;

    assign wr_tcfg    = write.wr && write.sel == SEL_TCFG;
    assign count_zero = (count == '0);

    always_comb begin
        tcfg_cur                            = '0;
        tcfg_cur[TCFG_EN]                   = tcfg_en;
        tcfg_cur[TCFG_PERIODIC]             = tcfg_periodic;
        tcfg_cur[31:TCFG_INITVAL_LSB]       = tcfg_initval;
    end

    // TCFG as it will look after this write
    assign tcfg_next = wset | (tcfg_cur & wkeep);

    always_ff @(posedge clk) begin
        if (reset) begin
            tid <= '0;
        end else if (write.wr && write.sel == SEL_TID) begin
            tid <= wset | (tid & wkeep);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tcfg_en <= 1'b0;
        end else if (wr_tcfg) begin
            tcfg_en <= tcfg_next[TCFG_EN];
        end
    end

    always_ff @(posedge clk) begin
        if (wr_tcfg) begin
            tcfg_periodic <= tcfg_next[TCFG_PERIODIC];
            tcfg_initval  <= tcfg_next[31:TCFG_INITVAL_LSB];
        end
    end

    // All ones means stopped; a one-shot wraps there from zero
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '1;
        end else if (wr_tcfg && tcfg_next[TCFG_EN]) begin
            count <= {tcfg_next[31:TCFG_INITVAL_LSB], 2'b00};
        end else if (tcfg_en && count != '1) begin
            if (count_zero && tcfg_periodic) begin
                count <= {tcfg_initval, 2'b00};
            end else begin
                count <= count - 32'd1;
            end
        end
    end

    // Expiry wins over a clear in the same cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            timer_int <= 1'b0;
        end else if (count_zero) begin
            timer_int <= 1'b1;
        end else if (write.wr && write.sel == SEL_TICLR && wset[TICLR_CLR]) begin
            timer_int <= 1'b0;
        end
    end

    assign timer_view = '{tid: tid, tcfg: tcfg_cur, tval: count};

endmodule

/* design/csr_read_mux.sv */
module csr_read_mux #(
    parameter int SAVE_COUNT = 4
) (
    input  csr_pkg::csr_sel_e    rd_sel,
    input  logic [3:0]           rd_save_idx,
    input  logic [$bits(csr_pkg::trap_regs_t)+32*SAVE_COUNT-1:0] trap_view,
    input  csr_pkg::timer_view_t timer_view,
    output logic [31:0]          rvalue
);
    import csr_pkg::*;

    trap_regs_t                  regs;
    logic [SAVE_COUNT-1:0][31:0] save;
    logic [31:0] crmd_word;
    logic [31:0] prmd_word;
    logic [31:0] ecfg_word;
    logic [31:0] estat_word;
    logic [31:0] eentry_word;
    logic [31:0] save_word;

    assign {save, regs} = trap_view;

    // Architectural layouts, reserved bits read as zero
    always_comb begin
        crmd_word                          = '0;
        crmd_word[CRMD_PLV_LSB +: 2]       = regs.crmd_plv;
        crmd_word[CRMD_IE]                 = regs.crmd_ie;
        crmd_word[CRMD_DA]                 = regs.crmd_da;
        crmd_word[CRMD_PG]                 = regs.crmd_pg;
        crmd_word[CRMD_DATF_LSB +: 2]      = regs.crmd_datf;
        crmd_word[CRMD_DATM_LSB +: 2]      = regs.crmd_datm;

        prmd_word                          = '0;
        prmd_word[PRMD_PPLV_LSB +: 2]      = regs.prmd_pplv;
        prmd_word[PRMD_PIE]                = regs.prmd_pie;

        ecfg_word                          = '0;
        ecfg_word[12:0]                    = regs.ecfg_lie;

        estat_word                         = '0;
        estat_word[ESTAT_IS_LSB +: ESTAT_IS_W] = regs.estat_is;
        estat_word[ESTAT_ECODE_LSB +: 6]   = regs.estat_ecode;
        estat_word[ESTAT_ESUBCODE_LSB +: 9] = regs.estat_esubcode;

        eentry_word                        = '0;
        eentry_word[31:EENTRY_VA_LSB]      = regs.eentry_va;
    end

    assign save_word = (int'(rd_save_idx) < SAVE_COUNT) ? save[rd_save_idx] : '0;

    always_comb begin
        case (rd_sel)
            SEL_CRMD:   rvalue = crmd_word;
            SEL_PRMD:   rvalue = prmd_word;
            SEL_ECFG:   rvalue = ecfg_word;
            SEL_ESTAT:  rvalue = estat_word;
            SEL_ERA:    rvalue = regs.era;
            SEL_BADV:   rvalue = regs.badv;
            SEL_EENTRY: rvalue = eentry_word;
            SEL_SAVE:   rvalue = save_word;
            SEL_TID:    rvalue = timer_view.tid;
            SEL_TCFG:   rvalue = timer_view.tcfg;
            SEL_TVAL:   rvalue = timer_view.tval;
            default:    rvalue = '0;
        endcase
    end

endmodule

/* design/csr_file.sv */
module csr_file #(
    parameter int SAVE_COUNT = 4
) (
    input  logic                 clk,
    input  logic                 reset,
    input  csr_pkg::csr_req_t    csr_req,
    input  logic                 valid,
    input  csr_pkg::trap_event_t trap,
    output logic [31:0]          csr_rvalue,
    output logic [31:0]          ex_entry,
    output logic [31:0]          era_pc,
    output logic                 has_int
);
    import csr_pkg::*;

    csr_write_t  write;
    csr_sel_e    rd_sel;
    logic [3:0]  rd_save_idx;
    logic        timer_int;
    timer_view_t timer_view;
    logic [$bits(trap_regs_t)+32*SAVE_COUNT-1:0] trap_view;

    csr_decode #(
        .SAVE_COUNT(SAVE_COUNT)
    ) i_decode (
        .req         (csr_req),
        .valid       (valid),
        .write       (write),
        .rd_sel      (rd_sel),
        .rd_save_idx (rd_save_idx)
    );

    csr_trap_state #(
        .SAVE_COUNT(SAVE_COUNT)
    ) i_trap_state (
        .clk       (clk),
        .reset     (reset),
        .write     (write),
        .trap      (trap),
        .timer_int (timer_int),
        .trap_view (trap_view),
        .ex_entry  (ex_entry),
        .era_pc    (era_pc),
        .has_int   (has_int)
    );

    csr_timer i_timer (
        .clk        (clk),
        .reset      (reset),
        .write      (write),
        .timer_int  (timer_int),
        .timer_view (timer_view)
    );

    csr_read_mux #(
        .SAVE_COUNT(SAVE_COUNT)
    ) i_read_mux (
        .rd_sel      (rd_sel),
        .rd_save_idx (rd_save_idx),
        .trap_view   (trap_view),
        .timer_view  (timer_view),
        .rvalue      (csr_rvalue)
    );

endmodule

/* tests/csr_file_props.sv */
module csr_trap_state_props (
    input logic       clk,
    input logic       reset,
    input logic       ex,
    input logic [1:0] crmd_plv,
    input logic       crmd_ie,
    input logic       crmd_da,
    input logic       crmd_pg,
    input logic [1:0] crmd_datf,
    input logic [1:0] crmd_datm,
    input logic       has_int
);
    timeunit 1ns;
    timeprecision 1ps;

    // Entry drops to kernel mode with interrupts off
    a_ex_clears_mode: assert property (@(posedge clk) disable iff (reset)
        ex |=> (crmd_plv == 2'b00 && !crmd_ie))
        else $error("CRMD PLV or IE not cleared one cycle after exception entry");

    a_int_needs_ie: assert property (@(posedge clk) disable iff (reset)
        has_int |-> crmd_ie)
        else $error("has_int high while CRMD.IE is clear");

    a_crmd_reset: assert property (@(posedge clk)
        $fell(reset) |-> (crmd_da && !crmd_pg && !crmd_ie && crmd_plv == 2'b00
                          && crmd_datf == 2'b00 && crmd_datm == 2'b00))
        else $error("CRMD does not hold its reset value after reset");

endmodule

bind csr_trap_state csr_trap_state_props i_props (
    .clk       (clk),
    .reset     (reset),
    .ex        (trap.ex),
    .crmd_plv  (crmd_plv),
    .crmd_ie   (crmd_ie),
    .crmd_da   (crmd_da),
    .crmd_pg   (crmd_pg),
    .crmd_datf (crmd_datf),
    .crmd_datm (crmd_datm),
    .has_int   (has_int)
);

/* tests/csr_file_tb.sv */
module csr_file_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import csr_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 4;
    localparam int POLL_LIMIT   = 64;

    // Cycle budget of each test in run order, polls at their limit
    localparam int TEST_CYCLES = RESET_CYCLES + 80 + 15 + 30 + 25
                               + (50 + POLL_LIMIT) + (40 + 2 * POLL_LIMIT);
    localparam int MARGIN_CYCLES = 200;

    logic        clk;
    logic        reset;
    csr_req_t    csr_req;
    logic        valid;
    trap_event_t trap;
    logic [31:0] csr_rvalue;
    logic [31:0] ex_entry;
    logic [31:0] era_pc;
    logic        has_int;

    int          error_count;
    int          test_errors;
    int          tests_run;
    int          tests_failed;

    csr_file #(
        .SAVE_COUNT(4)
    ) i_dut (
        .clk        (clk),
        .reset      (reset),
        .csr_req    (csr_req),
        .valid      (valid),
        .trap       (trap),
        .csr_rvalue (csr_rvalue),
        .ex_entry   (ex_entry),
        .era_pc     (era_pc),
        .has_int    (has_int)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("MISMATCH %s: expected %08h, actual %08h", name, expected, actual);
        error_count++;
        test_errors++;
    endtask

    task automatic report_failure(input string name, input string what);
        $display("ERROR %s: %s", name, what);
        error_count++;
        test_errors++;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    // Write lands at the second edge
    task automatic write_csr(input logic [13:0] num, input logic [31:0] value,
                             input logic [31:0] mask, input logic qualify);
        @(posedge clk);
        csr_req.num    <= num;
        csr_req.re     <= 1'b0;
        csr_req.we     <= 1'b1;
        csr_req.wvalue <= value;
        csr_req.wmask  <= mask;
        valid          <= qualify;
        @(posedge clk);
        csr_req.we <= 1'b0;
        valid      <= 1'b0;
    endtask

    // Read data is combinational, so sample mid-cycle
    task automatic read_csr(input logic [13:0] num, output logic [31:0] value);
        @(posedge clk);
        csr_req.num <= num;
        csr_req.re  <= 1'b1;
        @(negedge clk);
        value = csr_rvalue;
    endtask

    task automatic pulse_trap(input logic is_ertn, input ecode_e code,
                              input logic [8:0] subcode, input logic [31:0] pc,
                              input logic [31:0] vaddr);
        @(posedge clk);
        trap.ex       <= !is_ertn;
        trap.ertn     <= is_ertn;
        trap.ecode    <= code;
        trap.esubcode <= subcode;
        trap.pc       <= pc;
        trap.vaddr    <= vaddr;
        @(posedge clk);
        trap.ex   <= 1'b0;
        trap.ertn <= 1'b0;
    endtask

    // Full write first, since these registers have no reset value
    task automatic check_masked_write(input string name, input logic [13:0] num,
                                      input logic [31:0] impl_bits);
        logic [31:0] base;
        logic [31:0] value;
        logic [31:0] mask;
        logic [31:0] expected;
        logic [31:0] rdata;
        base  = $urandom();
        value = $urandom();
        mask  = $urandom();
        write_csr(num, base, 32'hffff_ffff, 1'b1);
        read_csr(num, rdata);
        if (rdata !== (base & impl_bits)) begin
            report_mismatch(name, base & impl_bits, rdata);
        end
        write_csr(num, value, mask, 1'b1);
        expected = ((value & mask) | (base & ~mask)) & impl_bits;
        read_csr(num, rdata);
        if (rdata !== expected) begin
            report_mismatch(name, expected, rdata);
        end
    endtask

    // Called right after the TCFG write edge
    task automatic check_countdown(input string name, input logic [31:0] start);
        logic [31:0] expected;
        expected    = start;
        csr_req.num <= CSR_TVAL;
        for (int k = 0; k <= int'(start); k++) begin
            @(negedge clk);
            if (csr_rvalue !== expected) begin
                report_mismatch(name, expected, csr_rvalue);
            end
            expected = expected - 32'd1;
        end
    endtask

    task automatic wait_timer_flag(input string name, input logic level);
        logic [31:0] value;
        int          polls;
        polls = 0;
        read_csr(CSR_ESTAT, value);
        while (value[TIMER_INT_BIT] !== level && polls < POLL_LIMIT) begin
            read_csr(CSR_ESTAT, value);
            polls++;
        end
        if (value[TIMER_INT_BIT] !== level) begin
            report_failure(name, $sformatf("timer flag did not reach %b within %0d reads",
                                           level, POLL_LIMIT));
        end
    endtask

    task automatic test_reset_and_masked_writes();
        logic [31:0] rdata;
        read_csr(CSR_CRMD, rdata);
        if (rdata !== 32'h0000_0008) begin
            report_mismatch("reset_crmd", 32'h0000_0008, rdata);
        end
        if (has_int !== 1'b0) begin
            report_failure("reset_has_int", "has_int is not low after reset");
        end
        check_masked_write("save0", CSR_SAVE0, 32'hffff_ffff);
        check_masked_write("save1", 14'h031, 32'hffff_ffff);
        check_masked_write("save2", 14'h032, 32'hffff_ffff);
        check_masked_write("save3", 14'h033, 32'hffff_ffff);
        check_masked_write("era", CSR_ERA, 32'hffff_ffff);
        check_masked_write("eentry", CSR_EENTRY, 32'hffff_ffc0);
        // LIE bit 10 is reserved
        write_csr(CSR_ECFG, 32'hffff_ffff, 32'hffff_ffff, 1'b1);
        read_csr(CSR_ECFG, rdata);
        if (rdata !== 32'h0000_1bff) begin
            report_mismatch("ecfg_lie", 32'h0000_1bff, rdata);
        end
        write_csr(CSR_ECFG, 32'h0, 32'hffff_ffff, 1'b1);
        read_csr(14'h003, rdata);
        if (rdata !== 32'h0) begin
            report_mismatch("unknown_csr", 32'h0, rdata);
        end
        read_csr(14'h034, rdata);
        if (rdata !== 32'h0) begin
            report_mismatch("save_out_of_range", 32'h0, rdata);
        end
        finish_test("reset_and_masked_writes");
    endtask

    task automatic test_valid_gating();
        logic [31:0] old;
        logic [31:0] rdata;
        read_csr(14'h031, old);
        write_csr(14'h031, ~old, 32'hffff_ffff, 1'b0);
        read_csr(14'h031, rdata);
        if (rdata !== old) begin
            report_mismatch("valid_gating", old, rdata);
        end
        finish_test("valid_gating");
    endtask

    task automatic test_exception_entry_return();
        logic [31:0] pc;
        logic [31:0] entry;
        logic [31:0] rdata;
        pc    = $urandom() & 32'hffff_fffc;
        entry = $urandom() & 32'hffff_ffc0;
        write_csr(CSR_EENTRY, entry, 32'hffff_ffff, 1'b1);
        write_csr(CSR_CRMD, 32'h0000_0007, 32'h0000_0007, 1'b1);
        read_csr(CSR_CRMD, rdata);
        if (rdata !== 32'h0000_000f) begin
            report_mismatch("crmd_before_ex", 32'h0000_000f, rdata);
        end
        pulse_trap(1'b0, ECODE_SYS, 9'd0, pc, 32'h0);
        read_csr(CSR_CRMD, rdata);
        if (rdata !== 32'h0000_0008) begin
            report_mismatch("crmd_after_ex", 32'h0000_0008, rdata);
        end
        read_csr(CSR_PRMD, rdata);
        if (rdata !== 32'h0000_0007) begin
            report_mismatch("prmd_after_ex", 32'h0000_0007, rdata);
        end
        read_csr(CSR_ERA, rdata);
        if (rdata !== pc) begin
            report_mismatch("era_after_ex", pc, rdata);
        end
        // SYS code in ESTAT bits 21:16
        read_csr(CSR_ESTAT, rdata);
        if (rdata !== 32'h000b_0000) begin
            report_mismatch("estat_after_ex", 32'h000b_0000, rdata);
        end
        read_csr(CSR_EENTRY, rdata);
        if (rdata !== entry) begin
            report_mismatch("eentry_after_ex", entry, rdata);
        end
        if (ex_entry !== entry) begin
            report_mismatch("ex_entry", entry, ex_entry);
        end
        pulse_trap(1'b1, ECODE_INT, 9'd0, 32'h0, 32'h0);
        read_csr(CSR_CRMD, rdata);
        if (rdata !== 32'h0000_000f) begin
            report_mismatch("crmd_after_ertn", 32'h0000_000f, rdata);
        end
        if (era_pc !== pc) begin
            report_mismatch("era_pc_after_ertn", pc, era_pc);
        end
        finish_test("exception_entry_return");
    endtask

    task automatic test_badv_capture();
        logic [31:0] pc;
        logic [31:0] vaddr;
        logic [31:0] rdata;
        pc    = $urandom();
        vaddr = $urandom();
        pulse_trap(1'b0, ECODE_ADE, ESUBCODE_ADEF, pc, vaddr);
        read_csr(CSR_BADV, rdata);
        if (rdata !== pc) begin
            report_mismatch("badv_adef", pc, rdata);
        end
        pc    = $urandom();
        vaddr = $urandom();
        pulse_trap(1'b0, ECODE_ALE, 9'd0, pc, vaddr);
        read_csr(CSR_BADV, rdata);
        if (rdata !== vaddr) begin
            report_mismatch("badv_ale", vaddr, rdata);
        end
        pulse_trap(1'b0, ECODE_SYS, 9'd0, $urandom(), $urandom());
        read_csr(CSR_BADV, rdata);
        if (rdata !== vaddr) begin
            report_mismatch("badv_sys", vaddr, rdata);
        end
        finish_test("badv_capture");
    endtask

    task automatic test_oneshot_timer();
        logic [29:0] initval;
        logic [31:0] rdata;
        initval = 30'd3;
        write_csr(CSR_CRMD, 32'h0, 32'h0000_0004, 1'b1);
        write_csr(CSR_TCFG, {initval, 2'b01}, 32'hffff_ffff, 1'b1);
        check_countdown("oneshot_tval", {initval, 2'b00});
        @(negedge clk);
        if (csr_rvalue !== 32'hffff_ffff) begin
            report_mismatch("oneshot_stop", 32'hffff_ffff, csr_rvalue);
        end
        wait_timer_flag("oneshot_flag", 1'b1);
        if (has_int !== 1'b0) begin
            report_failure("oneshot_has_int", "has_int high with LIE and IE clear");
        end
        write_csr(CSR_ECFG, 32'h0000_0800, 32'hffff_ffff, 1'b1);
        @(negedge clk);
        if (has_int !== 1'b0) begin
            report_failure("oneshot_has_int", "has_int high with IE clear");
        end
        write_csr(CSR_CRMD, 32'h0000_0004, 32'h0000_0004, 1'b1);
        @(negedge clk);
        if (has_int !== 1'b1) begin
            report_failure("oneshot_has_int", "has_int low with LIE 11 and IE set");
        end
        read_csr(CSR_TVAL, rdata);
        if (rdata !== 32'hffff_ffff) begin
            report_mismatch("oneshot_tval_held", 32'hffff_ffff, rdata);
        end
        write_csr(CSR_TICLR, 32'h1, 32'h1, 1'b1);
        @(negedge clk);
        if (has_int !== 1'b0) begin
            report_failure("oneshot_clear", "has_int still high after TICLR write");
        end
        read_csr(CSR_ESTAT, rdata);
        if (rdata[TIMER_INT_BIT] !== 1'b0) begin
            report_failure("oneshot_clear", "timer flag still set after TICLR write");
        end
        read_csr(CSR_TICLR, rdata);
        if (rdata !== 32'h0) begin
            report_mismatch("ticlr_read", 32'h0, rdata);
        end
        finish_test("oneshot_timer");
    endtask

    task automatic test_periodic_timer();
        logic [29:0] initval;
        logic [31:0] rdata;
        initval = 30'd2;
        write_csr(CSR_TCFG, {initval, 2'b11}, 32'hffff_ffff, 1'b1);
        check_countdown("periodic_tval", {initval, 2'b00});
        @(negedge clk);
        if (csr_rvalue !== {initval, 2'b00}) begin
            report_mismatch("periodic_reload", {initval, 2'b00}, csr_rvalue);
        end
        wait_timer_flag("periodic_flag", 1'b1);
        write_csr(CSR_TICLR, 32'h1, 32'h1, 1'b1);
        read_csr(CSR_ESTAT, rdata);
        if (rdata[TIMER_INT_BIT] !== 1'b0) begin
            report_failure("periodic_clear", "timer flag still set after TICLR write");
        end
        wait_timer_flag("periodic_reflag", 1'b1);
        write_csr(CSR_TCFG, 32'h0, 32'hffff_ffff, 1'b1);
        finish_test("periodic_timer");
    endtask

    initial begin
        void'($urandom(32'h7e8a));
        error_count  = 0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        reset   <= 1'b1;
        valid   <= 1'b0;
        csr_req <= '0;
        trap    <= '0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        test_reset_and_masked_writes();
        test_valid_gating();
        test_exception_entry_return();
        test_badv_capture();
        test_oneshot_timer();
        test_periodic_timer();

        $display("summary: %0d tests run, %0d failed, %0d errors",
                 tests_run, tests_failed, error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        #((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, tests did not finish",
                 TEST_CYCLES + MARGIN_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

/* tb.f */
design/csr_pkg.sv
design/csr_decode.sv
design/csr_trap_state.sv
design/csr_timer.sv
design/csr_read_mux.sv
design/csr_file.sv
tests/csr_file_props.sv
tests/csr_file_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= csr_file_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= *** TEST PASSED ***

SIM := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard design/*.sv tests/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
